// ==== files.f ====
+incdir+verilog
verilog/npc_pkg.sv
verilog/pipe_ctrl_if.sv
verilog/stage_reg.sv
verilog/hazard_ctrl.sv
verilog/fetch_stage.sv
verilog/decode_regfile.sv
verilog/execute_stage.sv
verilog/mem_access.sv
verilog/npc_pipeline.sv
testbench/npc_assertions.sv
testbench/tb_npc.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_npc -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_npc > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "Regression passed" sim.log; then
    exit 0
fi
echo "Pass line not found in sim.log"
exit 1

// ==== testbench/tb_npc.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "npc_config.svh"

module tb_npc;
    import npc_pkg::*;

    localparam int NUM_ROWS       = 4;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 200;

    // One program with its data word and expected results
    typedef struct packed {
        logic [7:0][31:0] prog;
        xlen_t            data_init;
        xlen_t            exp_exit;
        xlen_t            exp_word0;
    } test_row_t;

    logic       clk;
    logic       rst;
    logic       ifu_req;
    xlen_t      ifu_addr;
    logic       ifu_rvalid;
    xlen_t      ifu_rdata;
    logic       lsu_req;
    logic       lsu_wen;
    xlen_t      lsu_addr;
    xlen_t      lsu_wdata;
    logic [3:0] lsu_wmask;
    logic       lsu_rvalid;
    xlen_t      lsu_rdata;
    logic       ebreak_flag;
    xlen_t      exit_code;

    test_row_t rows [NUM_ROWS];
    xlen_t     rom [8];
    xlen_t     ram [16];
    int        cur_row = 0;
    int        cycles = 0;
    integer    seed = 35849;

    npc_pipeline i_dut (
        .clk(clk), .rst(rst),
        .ifu_req(ifu_req), .ifu_addr(ifu_addr),
        .ifu_rvalid(ifu_rvalid), .ifu_rdata(ifu_rdata),
        .lsu_req(lsu_req), .lsu_wen(lsu_wen), .lsu_addr(lsu_addr),
        .lsu_wdata(lsu_wdata), .lsu_wmask(lsu_wmask),
        .lsu_rvalid(lsu_rvalid), .lsu_rdata(lsu_rdata),
        .ebreak_flag(ebreak_flag), .exit_code(exit_code)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // RV32I encoders
    function automatic xlen_t addi(int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], OP_IMM};
    endfunction

    function automatic xlen_t add_rr(int rd, int rs1, int rs2);
        return {7'b0000000, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], OP_REG};
    endfunction

    function automatic xlen_t sub_rr(int rd, int rs1, int rs2);
        return {FUNCT7_SUB, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], OP_REG};
    endfunction

    function automatic xlen_t lw(int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], OP_LOAD};
    endfunction

    function automatic xlen_t sw(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic xlen_t beq(int rs1, int rs2, int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b000, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic xlen_t jal(int rd, int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OP_JAL};
    endfunction

    function automatic xlen_t ebreak_inst();
        return {12'h001, 13'd0, OP_SYSTEM};
    endfunction

    // Past the end of the program the ROM returns ebreak
    function automatic xlen_t fetch_word(xlen_t addr);
        xlen_t off;
        off = (addr - `NPC_RESET_PC) >> 2;
        if (off < 32'd8) begin
            return rom[off[2:0]];
        end
        return ebreak_inst();
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic build_table();
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int i = 0; i < 8; i++) begin
                rows[r].prog[i] = ebreak_inst();
            end
        end
        // Plain arithmetic into x10
        rows[0].prog[0] = addi(1, 0, 100);
        rows[0].prog[1] = addi(2, 0, 23);
        rows[0].prog[2] = addi(3, 0, 7);
        rows[0].prog[3] = add_rr(4, 1, 2);
        rows[0].prog[4] = sub_rr(10, 4, 3);
        rows[0].data_init = 32'h1234_5678;
        rows[0].exp_exit  = 32'd100 + 32'd23 - 32'd7;
        rows[0].exp_word0 = 32'h1234_5678;
        // Every instruction reads the one before it
        rows[1].prog[0] = addi(10, 0, 1);
        rows[1].prog[1] = addi(10, 10, 2);
        rows[1].prog[2] = add_rr(10, 10, 10);
        rows[1].prog[3] = addi(6, 0, -1);
        rows[1].prog[4] = sub_rr(10, 10, 6);
        rows[1].prog[5] = add_rr(10, 10, 10);
        rows[1].data_init = 32'h0000_0000;
        rows[1].exp_exit  = xlen_t'(((1 + 2) * 2 - (-1)) * 2);
        rows[1].exp_word0 = 32'h0000_0000;
        // Store then load back through address 0
        rows[2].prog[0] = addi(7, 0, 12'h5a5);
        rows[2].prog[1] = add_rr(7, 7, 7);
        rows[2].prog[2] = sw(7, 0, 0);
        rows[2].prog[3] = addi(10, 0, 0);
        rows[2].prog[4] = lw(10, 0, 0);
        rows[2].data_init = 32'hdead_beef;
        rows[2].exp_exit  = 32'h5a5 + 32'h5a5;
        rows[2].exp_word0 = 32'h5a5 + 32'h5a5;
        // Sentinels sit in slots 3 and 6
        rows[3].prog[0] = addi(10, 0, 10);
        rows[3].prog[1] = addi(8, 0, 10);
        rows[3].prog[2] = beq(10, 8, 8);
        rows[3].prog[3] = addi(10, 10, 1000);
        rows[3].prog[4] = beq(10, 0, 8);
        rows[3].prog[5] = jal(9, 8);
        rows[3].prog[6] = addi(10, 10, 500);
        rows[3].prog[7] = addi(10, 10, 5);
        rows[3].data_init = 32'h0bad_f00d;
        rows[3].exp_exit  = 32'd10 + 32'd5;
        rows[3].exp_word0 = 32'h0bad_f00d;
    endtask

    // Instruction ROM and data RAM, each answering 1 to 3 cycles after a request
    initial begin : mem_model
        int    ifu_left;
        int    lsu_left;
        xlen_t ifu_addr_q;
        xlen_t lsu_addr_q;
        ifu_left   = 0;
        lsu_left   = 0;
        ifu_addr_q = '0;
        lsu_addr_q = '0;
        ifu_rvalid = 1'b0;
        ifu_rdata  = '0;
        lsu_rvalid = 1'b0;
        lsu_rdata  = '0;
        forever begin
            @(negedge clk);
            if (rst) begin
                ifu_left = 0;
                lsu_left = 0;
                for (int i = 0; i < 8; i++) begin
                    rom[i] = rows[cur_row].prog[i];
                end
                for (int i = 0; i < 16; i++) begin
                    ram[i] = (i == 0) ? rows[cur_row].data_init : '0;
                end
            end else begin
                if (ifu_req) begin
                    ifu_addr_q = ifu_addr;
                    ifu_left   = 1 + int'({$random(seed)} % 3);
                end
                if (lsu_req) begin
                    lsu_addr_q = lsu_addr;
                    lsu_left   = 1 + int'({$random(seed)} % 3);
                    for (int b = 0; b < 4; b++) begin
                        if (lsu_wen && lsu_wmask[b]) begin
                            ram[lsu_addr[5:2]][8*b +: 8] = lsu_wdata[8*b +: 8];
                        end
                    end
                end
            end
            @(posedge clk);
            #1;
            ifu_rvalid = (ifu_left == 1);
            lsu_rvalid = (lsu_left == 1);
            if (ifu_left == 1) begin
                ifu_rdata = fetch_word(ifu_addr_q);
            end
            if (lsu_left == 1) begin
                lsu_rdata = ram[lsu_addr_q[5:2]];
            end
            if (ifu_left > 0) begin
                ifu_left--;
            end
            if (lsu_left > 0) begin
                lsu_left--;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            fail_run($sformatf("Timeout: ebreak not reached within %0d cycles",
                               TIMEOUT_CYCLES));
        end
    end

    task automatic run_row(input int r);
        @(posedge clk);
        #1;
        cur_row = r;
        rst     = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        while (!ebreak_flag) begin
            @(negedge clk);
        end
        assert (exit_code == rows[r].exp_exit) else begin
            fail_run($sformatf("ERR %0t: row %0d exit_code %h, expected %h",
                               $time, r, exit_code, rows[r].exp_exit));
        end
        assert (ram[0] == rows[r].exp_word0) else begin
            fail_run($sformatf("ERR %0t: row %0d data word 0 is %h, expected %h",
                               $time, r, ram[0], rows[r].exp_word0));
        end
    endtask

    initial begin
        rst = 1'b1;
        build_table();
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        if (i_dut.u_assertions.failures == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            fail_run("A port assertion failed during the run");
        end
    end

endmodule

`default_nettype wire

// ==== testbench/npc_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

module npc_assertions (
    input logic           clk,
    input logic           rst,
    input logic           ifu_req,
    input logic           lsu_req,
    input logic           ebreak_flag,
    input npc_pkg::xlen_t exit_code
);

    int failures = 0;

    // Only one fetch may be outstanding
    ifu_single_pulse: assert property (@(posedge clk) disable iff (rst) ifu_req |=> !ifu_req)
    else begin
        $error("ifu_req high in two consecutive cycles");
        failures++;
    end

    // The data port waits for its acknowledge before the next access
    lsu_single_pulse: assert property (@(posedge clk) disable iff (rst) lsu_req |=> !lsu_req)
    else begin
        $error("lsu_req high in two consecutive cycles");
        failures++;
    end

    // Halt is sticky until the next reset, and the exit code stays put
    halt_sticky: assert property (@(posedge clk) disable iff (rst)
                                  ebreak_flag |=> ebreak_flag && $stable(exit_code))
    else begin
        $error("ebreak_flag dropped or exit_code changed while halted");
        failures++;
    end

    quiet_after_reset: assert property (@(posedge clk) $fell(rst) |-> !ifu_req && !lsu_req)
    else begin
        $error("request active right after reset");
        failures++;
    end

endmodule

bind npc_pipeline npc_assertions u_assertions (
    .clk(clk),
    .rst(rst),
    .ifu_req(ifu_req),
    .lsu_req(lsu_req),
    .ebreak_flag(ebreak_flag),
    .exit_code(exit_code)
);

`default_nettype wire

// ==== verilog/npc_pipeline.sv ====
`timescale 1ns/1ns
`default_nettype none

module npc_pipeline (
    input  logic           clk,
    input  logic           rst,
    output logic           ifu_req,
    output npc_pkg::xlen_t ifu_addr,
    input  logic           ifu_rvalid,
    input  npc_pkg::xlen_t ifu_rdata,
    output logic           lsu_req,
    output logic           lsu_wen,
    output npc_pkg::xlen_t lsu_addr,
    output npc_pkg::xlen_t lsu_wdata,
    output logic [3:0]     lsu_wmask,
    input  logic           lsu_rvalid,
    input  npc_pkg::xlen_t lsu_rdata,
    output logic           ebreak_flag,
    output npc_pkg::xlen_t exit_code
);
    import npc_pkg::*;

    pipe_ctrl_if ctl ();

    logic         if_id_valid;
    xlen_t        if_id_pc;
    xlen_t        if_id_inst;
    logic         dec_valid;
    ex_payload_t  dec_data;
    logic         ex_valid;
    ex_payload_t  ex_data;
    logic         exe_valid;
    mem_payload_t exe_data;
    logic         mem_valid;
    mem_payload_t mem_data;
    logic         lsu_out_valid;
    wb_payload_t  lsu_out_data;
    logic         wb_valid;
    wb_payload_t  wb_data;

    // Destinations still in flight, seen by the RAW check
    assign ctl.ex_rd   = ex_data.rd;
    assign ctl.ex_wen  = ex_valid && ex_data.reg_wen;
    assign ctl.mem_rd  = mem_data.rd;
    assign ctl.mem_wen = mem_valid && mem_data.reg_wen;
    assign ctl.wb_rd   = wb_data.rd;
    assign ctl.wb_wen  = wb_valid && wb_data.reg_wen;

    hazard_ctrl u_hazard (.ctrl(ctl.ctrl));

    fetch_stage u_fetch (
        .clk(clk), .rst(rst), .ctl(ctl.fetch),
        .ifu_req(ifu_req), .ifu_addr(ifu_addr),
        .ifu_rvalid(ifu_rvalid), .ifu_rdata(ifu_rdata),
        .if_id_valid(if_id_valid), .if_id_pc(if_id_pc), .if_id_inst(if_id_inst)
    );

    decode_regfile u_decode (
        .clk(clk), .rst(rst), .ctl(ctl.decode),
        .if_id_valid(if_id_valid), .if_id_pc(if_id_pc), .if_id_inst(if_id_inst),
        .ex_valid(dec_valid), .ex_data(dec_data),
        .wb_valid(wb_valid), .wb_data(wb_data),
        .ebreak_flag(ebreak_flag), .exit_code(exit_code)
    );

    stage_reg #(.payload_t(ex_payload_t)) u_id_ex (
        .clk(clk), .rst(rst), .hold(ctl.hold_back), .flush(ctl.flush_front),
        .in_valid(dec_valid), .in_data(dec_data),
        .out_valid(ex_valid), .out_data(ex_data)
    );

    execute_stage u_execute (
        .ctl(ctl.execute),
        .in_valid(ex_valid), .in_data(ex_data),
        .out_valid(exe_valid), .out_data(exe_data)
    );

    stage_reg #(.payload_t(mem_payload_t)) u_ex_mem (
        .clk(clk), .rst(rst), .hold(ctl.hold_back), .flush(1'b0),
        .in_valid(exe_valid), .in_data(exe_data),
        .out_valid(mem_valid), .out_data(mem_data)
    );

    mem_access u_mem (
        .clk(clk), .rst(rst), .ctl(ctl.mem),
        .in_valid(mem_valid), .in_data(mem_data),
        .out_valid(lsu_out_valid), .out_data(lsu_out_data),
        .lsu_req(lsu_req), .lsu_wen(lsu_wen), .lsu_addr(lsu_addr),
        .lsu_wdata(lsu_wdata), .lsu_wmask(lsu_wmask),
        .lsu_rvalid(lsu_rvalid), .lsu_rdata(lsu_rdata)
    );

    stage_reg #(.payload_t(wb_payload_t)) u_mem_wb (
        .clk(clk), .rst(rst), .hold(1'b0), .flush(1'b0),
        .in_valid(lsu_out_valid), .in_data(lsu_out_data),
        .out_valid(wb_valid), .out_data(wb_data)
    );

endmodule

`default_nettype wire

// ==== verilog/mem_access.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "npc_config.svh"

module mem_access (
    input  logic                  clk,
    input  logic                  rst,
    pipe_ctrl_if.mem              ctl,
    input  logic                  in_valid,
    input  npc_pkg::mem_payload_t in_data,
    output logic                  out_valid,
    output npc_pkg::wb_payload_t  out_data,
    output logic                  lsu_req,
    output logic                  lsu_wen,
    output npc_pkg::xlen_t        lsu_addr,
    output npc_pkg::xlen_t        lsu_wdata,
    output logic [3:0]            lsu_wmask,
    input  logic                  lsu_rvalid,
    input  npc_pkg::xlen_t        lsu_rdata
);
    import npc_pkg::*;

    typedef enum logic {S_IDLE, S_WAIT} state_t;

    state_t state;
    logic   is_mem;
    logic   done;

    assign is_mem = in_valid && (in_data.mem_ren || in_data.mem_wen);
    assign done   = (state == S_WAIT) && lsu_rvalid;

    // Request goes out in the first cycle the access sits in EX/MEM
    assign lsu_req   = is_mem && (state == S_IDLE);
    assign lsu_wen   = lsu_req && in_data.mem_wen;
    assign lsu_addr  = in_data.alu_result;
    assign lsu_wdata = in_data.store_data;
    assign lsu_wmask = `NPC_FULL_WMASK;

    assign ctl.mem_busy = is_mem && !done;
    assign out_valid    = in_valid && (!is_mem || done);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: if (lsu_req) state <= S_WAIT;
                S_WAIT: if (lsu_rvalid) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_comb begin
        out_data.result    = in_data.mem_ren ? lsu_rdata : in_data.alu_result;
        out_data.rd        = in_data.rd;
        out_data.reg_wen   = in_data.reg_wen;
        out_data.is_ebreak = in_data.is_ebreak;
    end

endmodule

`default_nettype wire

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    pipe_ctrl_if.execute           ctl,
    input  logic                   in_valid,
    input  npc_pkg::ex_payload_t   in_data,
    output logic                   out_valid,
    output npc_pkg::mem_payload_t  out_data
);
    import npc_pkg::*;

    xlen_t alu_out;
    logic  taken;

    // Loads and stores reuse the immediate add for the address
    always_comb begin
        if (in_data.is_jal) begin
            alu_out = in_data.pc + 32'd4;
        end else if (in_data.is_reg_op) begin
            alu_out = in_data.is_sub ? in_data.rs1_val - in_data.rs2_val
                                     : in_data.rs1_val + in_data.rs2_val;
        end else begin
            alu_out = in_data.rs1_val + in_data.imm;
        end
    end

    assign taken = in_data.is_jal ||
                   (in_data.is_branch && (in_data.rs1_val == in_data.rs2_val));

    // Held back while MEM is busy so the branch is not flushed out of ID/EX
    assign ctl.redirect    = in_valid && taken && !ctl.hold_back;
    assign ctl.redirect_pc = in_data.pc + in_data.imm;

    assign out_valid = in_valid;

    always_comb begin
        out_data.alu_result = alu_out;
        out_data.store_data = in_data.rs2_val;
        out_data.rd         = in_data.rd;
        out_data.reg_wen    = in_data.reg_wen;
        out_data.mem_ren    = in_data.mem_ren;
        out_data.mem_wen    = in_data.mem_wen;
        out_data.is_ebreak  = in_data.is_ebreak;
    end

endmodule

`default_nettype wire

// ==== verilog/decode_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "npc_config.svh"

module decode_regfile (
    input  logic                 clk,
    input  logic                 rst,
    pipe_ctrl_if.decode          ctl,
    input  logic                 if_id_valid,
    input  npc_pkg::xlen_t       if_id_pc,
    input  npc_pkg::xlen_t       if_id_inst,
    output logic                 ex_valid,
    output npc_pkg::ex_payload_t ex_data,
    input  logic                 wb_valid,
    input  npc_pkg::wb_payload_t wb_data,
    output logic                 ebreak_flag,
    output npc_pkg::xlen_t       exit_code
);
    import npc_pkg::*;

    xlen_t    regs [`NPC_NUM_REGS];
    logic [6:0] opcode;
    reg_idx_t rs1;
    reg_idx_t rs2;
    logic     is_imm;
    logic     is_reg;
    logic     is_load;
    logic     is_store;
    logic     is_branch;
    logic     is_jal;
    xlen_t    imm;

    assign opcode    = if_id_inst[6:0];
    assign rs1       = if_id_inst[19:15];
    assign rs2       = if_id_inst[24:20];
    assign is_imm    = (opcode == OP_IMM);
    assign is_reg    = (opcode == OP_REG);
    assign is_load   = (opcode == OP_LOAD);
    assign is_store  = (opcode == OP_STORE);
    assign is_branch = (opcode == OP_BRANCH);
    assign is_jal    = (opcode == OP_JAL);

    // Immediate by format
    always_comb begin
        if (is_store) begin
            imm = {{20{if_id_inst[31]}}, if_id_inst[31:25], if_id_inst[11:7]};
        end else if (is_branch) begin
            imm = {{19{if_id_inst[31]}}, if_id_inst[31], if_id_inst[7],
                   if_id_inst[30:25], if_id_inst[11:8], 1'b0};
        end else if (is_jal) begin
            imm = {{11{if_id_inst[31]}}, if_id_inst[31], if_id_inst[19:12],
                   if_id_inst[20], if_id_inst[30:21], 1'b0};
        end else begin
            imm = {{20{if_id_inst[31]}}, if_id_inst[31:20]};
        end
    end

    assign ctl.id_rs1      = rs1;
    assign ctl.id_rs2      = rs2;
    assign ctl.id_uses_rs1 = if_id_valid && (is_imm || is_reg || is_load || is_store || is_branch);
    assign ctl.id_uses_rs2 = if_id_valid && (is_reg || is_store || is_branch);
    assign ctl.halted      = ebreak_flag;

    assign ex_valid = if_id_valid && !ctl.stall_id && !ctl.flush_front;

    always_comb begin
        ex_data.pc        = if_id_pc;
        // x0 is hardwired to zero
        ex_data.rs1_val   = (rs1 == reg_idx_t'(0)) ? '0 : regs[rs1];
        ex_data.rs2_val   = (rs2 == reg_idx_t'(0)) ? '0 : regs[rs2];
        ex_data.imm       = imm;
        ex_data.rd        = if_id_inst[11:7];
        ex_data.reg_wen   = is_imm || is_reg || is_load || is_jal;
        ex_data.mem_ren   = is_load;
        ex_data.mem_wen   = is_store;
        ex_data.is_branch = is_branch;
        ex_data.is_jal    = is_jal;
        ex_data.is_sub    = is_reg && (if_id_inst[31:25] == FUNCT7_SUB);
        ex_data.is_reg_op = is_reg;
        ex_data.is_ebreak = (opcode == OP_SYSTEM) && (if_id_inst[31:20] == 12'h001);
    end

    // Writeback commits at the edge that ends the WB cycle
    always_ff @(posedge clk) begin
        if (wb_valid && wb_data.reg_wen && (wb_data.rd != reg_idx_t'(0))) begin
            regs[wb_data.rd] <= wb_data.result;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ebreak_flag <= 1'b0;
            exit_code   <= '0;
        end else if (wb_valid && wb_data.is_ebreak && !ebreak_flag) begin
            ebreak_flag <= 1'b1;
            exit_code   <= regs[reg_idx_t'(10)];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fetch_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "npc_config.svh"

module fetch_stage (
    input  logic           clk,
    input  logic           rst,
    pipe_ctrl_if.fetch     ctl,
    output logic           ifu_req,
    output npc_pkg::xlen_t ifu_addr,
    input  logic           ifu_rvalid,
    input  npc_pkg::xlen_t ifu_rdata,
    output logic           if_id_valid,
    output npc_pkg::xlen_t if_id_pc,
    output npc_pkg::xlen_t if_id_inst
);
    import npc_pkg::*;

    xlen_t pc;
    logic  waiting;
    logic  discard;
    logic  resp_ok;
    logic  consumed;
    logic  slot_free;
    logic  issue;

    assign ifu_addr = pc;

    // Response belongs to the current path
    assign resp_ok   = waiting && !discard && ifu_rvalid && !ctl.flush_front;
    assign consumed  = if_id_valid && !ctl.stall_id && !ctl.flush_front;
    assign slot_free = !if_id_valid || consumed || ctl.flush_front;

    // One fetch in flight, next one only once the slot will be empty
    assign issue = (!waiting || ifu_rvalid) && slot_free && !resp_ok &&
                   !ctl.stall_id && !ctl.stop_fetch;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc          <= `NPC_RESET_PC;
            ifu_req     <= 1'b0;
            waiting     <= 1'b0;
            discard     <= 1'b0;
            if_id_valid <= 1'b0;
        end else begin
            ifu_req <= issue;
            if (ifu_rvalid) begin
                waiting <= 1'b0;
                discard <= 1'b0;
            end
            if (issue) begin
                waiting <= 1'b1;
            end
            if (ctl.flush_front) begin
                pc          <= ctl.redirect_pc;
                if_id_valid <= 1'b0;
                // Fetch still out there now returns stale data
                discard     <= waiting && !ifu_rvalid;
            end else if (resp_ok) begin
                pc          <= pc + 32'd4;
                if_id_valid <= 1'b1;
            end else if (consumed) begin
                if_id_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (resp_ok) begin
            if_id_pc   <= pc;
            if_id_inst <= ifu_rdata;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/hazard_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module hazard_ctrl (
    pipe_ctrl_if.ctrl ctrl
);
    import npc_pkg::*;

    logic rs1_hit;
    logic rs2_hit;
    logic raw_stall;

    // No forwarding, so any older writer of a source blocks decode
    assign rs1_hit = ctrl.id_uses_rs1 && (ctrl.id_rs1 != reg_idx_t'(0)) &&
                     ((ctrl.ex_wen  && (ctrl.ex_rd  == ctrl.id_rs1)) ||
                      (ctrl.mem_wen && (ctrl.mem_rd == ctrl.id_rs1)) ||
                      (ctrl.wb_wen  && (ctrl.wb_rd  == ctrl.id_rs1)));

    assign rs2_hit = ctrl.id_uses_rs2 && (ctrl.id_rs2 != reg_idx_t'(0)) &&
                     ((ctrl.ex_wen  && (ctrl.ex_rd  == ctrl.id_rs2)) ||
                      (ctrl.mem_wen && (ctrl.mem_rd == ctrl.id_rs2)) ||
                      (ctrl.wb_wen  && (ctrl.wb_rd  == ctrl.id_rs2)));

    assign raw_stall = rs1_hit || rs2_hit;

    // Memory back-pressure freezes EX and everything behind it
    assign ctrl.hold_back   = ctrl.mem_busy;
    assign ctrl.stall_id    = ctrl.mem_busy || raw_stall;
    assign ctrl.flush_front = ctrl.redirect;
    assign ctrl.stop_fetch  = ctrl.halted;

endmodule

`default_nettype wire

// ==== verilog/stage_reg.sv ====
`timescale 1ns/1ns
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     hold,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // Flush wins over hold, a flushed slot becomes a bubble
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (!hold) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/pipe_ctrl_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface pipe_ctrl_if;
    import npc_pkg::*;

    // Sources of the instruction sitting in decode
    reg_idx_t id_rs1;
    reg_idx_t id_rs2;
    logic     id_uses_rs1;
    logic     id_uses_rs2;

    // Pending destinations, already qualified by stage valid
    reg_idx_t ex_rd;
    logic     ex_wen;
    reg_idx_t mem_rd;
    logic     mem_wen;
    reg_idx_t wb_rd;
    logic     wb_wen;

    logic     redirect;
    xlen_t    redirect_pc;
    logic     mem_busy;
    logic     halted;

    // Commands from the hazard unit
    logic     stall_id;
    logic     hold_back;
    logic     flush_front;
    logic     stop_fetch;

    modport ctrl (
        input  id_rs1, id_rs2, id_uses_rs1, id_uses_rs2,
        input  ex_rd, ex_wen, mem_rd, mem_wen, wb_rd, wb_wen,
        input  redirect, mem_busy, halted,
        output stall_id, hold_back, flush_front, stop_fetch
    );

    modport fetch (
        input stall_id, flush_front, stop_fetch, redirect_pc
    );

    modport decode (
        output id_rs1, id_rs2, id_uses_rs1, id_uses_rs2, halted,
        input  stall_id, flush_front
    );

    modport execute (
        input  hold_back,
        output redirect, redirect_pc
    );

    modport mem (
        output mem_busy
    );

endinterface

`default_nettype wire

// ==== verilog/npc_pkg.sv ====
`default_nettype none

package npc_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_idx_t;

    // RV32I major opcodes still in use
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    // funct7 of SUB, ADD has all zeros
    localparam logic [6:0] FUNCT7_SUB = 7'b0100000;

    // Decode to execute
    typedef struct packed {
        xlen_t    pc;
        xlen_t    rs1_val;
        xlen_t    rs2_val;
        xlen_t    imm;
        reg_idx_t rd;
        logic     reg_wen;
        logic     mem_ren;
        logic     mem_wen;
        logic     is_branch;
        logic     is_jal;
        logic     is_sub;
        logic     is_reg_op;
        logic     is_ebreak;
    } ex_payload_t;

    // Execute to memory
    typedef struct packed {
        xlen_t    alu_result;
        xlen_t    store_data;
        reg_idx_t rd;
        logic     reg_wen;
        logic     mem_ren;
        logic     mem_wen;
        logic     is_ebreak;
    } mem_payload_t;

    // Memory to writeback
    typedef struct packed {
        xlen_t    result;
        reg_idx_t rd;
        logic     reg_wen;
        logic     is_ebreak;
    } wb_payload_t;

endpackage

`default_nettype wire

// ==== verilog/npc_config.svh ====
`ifndef NPC_CONFIG_SVH
`define NPC_CONFIG_SVH

// Address of the first instruction fetched after reset
`define NPC_RESET_PC 32'h3000_0000

// Architectural integer registers, x0 included
`define NPC_NUM_REGS 32

// Only whole-word stores exist
`define NPC_FULL_WMASK 4'b1111

`endif
